// File: cpu_pkg.sv
package cpu_pkg;

    localparam int xlen      = 32;
    localparam int rob_depth = 8;
    localparam int tag_w     = 3;
    localparam int rs_depth  = 4;
    localparam int iq_depth  = 4;

    localparam logic [31:0] reset_pc = 32'h0000_0000;

    localparam logic [6:0] op_reg = 7'b0110011;
    localparam logic [6:0] op_imm = 7'b0010011;
    localparam logic [6:0] op_lui = 7'b0110111;

    // pass forwards operand b, used by lui and unsupported opcodes
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sltu,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_pass
    } alu_op_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_view_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_view_t;

    typedef union packed {
        r_view_t r;
        i_view_t i;
    } inst_u;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic [31:0] adr;
    } wb_req_t;

    typedef struct packed {
        logic [xlen-1:0] pc;
        inst_u           inst;
    } fetch_pkt_t;

    typedef struct packed {
        logic             valid;
        logic [tag_w-1:0] tag;
        logic [4:0]       rd;
        logic             writes;
        alu_op_e          op;
        logic [xlen-1:0]  src1_val;
        logic [tag_w-1:0] src1_tag;
        logic             src1_rdy;
        logic [xlen-1:0]  src2_val;
        logic [tag_w-1:0] src2_tag;
        logic             src2_rdy;
        logic [xlen-1:0]  pc;
    } dispatch_t;

    typedef struct packed {
        logic             valid;
        logic [tag_w-1:0] tag;
        alu_op_e          op;
        logic [xlen-1:0]  src_a;
        logic [xlen-1:0]  src_b;
    } issue_t;

    typedef struct packed {
        logic             valid;
        logic [tag_w-1:0] tag;
        logic [xlen-1:0]  data;
    } cdb_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic [4:0]      rd;
        logic            writes;
        logic [xlen-1:0] data;
    } commit_t;

    typedef struct packed {
        logic            done;
        logic [xlen-1:0] value;
    } rob_read_t;

endpackage

// File: fetch_unit.sv
module fetch_unit
import cpu_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            wb_ack_i,
    input  logic [xlen-1:0] wb_dat_i,
    input  logic            iq_full_i,
    output wb_req_t         wb_o,
    output logic            push_o,
    output fetch_pkt_t      pkt_o
);

    logic [xlen-1:0] pc;
    logic            busy;

    // one classic read cycle per word, address held until ack
    assign wb_o.cyc = busy;
    assign wb_o.stb = busy;
    assign wb_o.adr = pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc     <= reset_pc;
            busy   <= 1'b0;
            push_o <= 1'b0;
        end else begin
            push_o <= 1'b0;
            if (busy) begin
                if (wb_ack_i) begin
                    busy   <= 1'b0;
                    push_o <= 1'b1;
                    pc     <= pc + 32'd4;
                end
            end else if (!iq_full_i && !push_o) begin
                // a pending push is not yet counted in the queue
                busy <= 1'b1;
            end
        end
    end

    // word and its address, sampled in the ack cycle
    always_ff @(posedge clk) begin
        if (busy && wb_ack_i) begin
            pkt_o.pc   <= pc;
            pkt_o.inst <= wb_dat_i;
        end
    end

endmodule

// File: inst_queue.sv
module inst_queue
import cpu_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       push_i,
    input  fetch_pkt_t pkt_i,
    input  logic       pop_i,
    output logic       full_o,
    output logic       valid_o,
    output fetch_pkt_t pkt_o
);

    fetch_pkt_t                    mem [iq_depth];
    logic [$clog2(iq_depth)-1:0]   head;
    logic [$clog2(iq_depth)-1:0]   tail;
    logic [$clog2(iq_depth):0]     count;

    assign full_o  = count == ($clog2(iq_depth) + 1)'(iq_depth);
    assign valid_o = count != '0;
    assign pkt_o   = mem[head];

    always_ff @(posedge clk) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (push_i) tail <= tail + 1'b1;
            if (pop_i) head <= head + 1'b1;
            case ({push_i, pop_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push_i) mem[tail] <= pkt_i;
    end

endmodule

// File: decode_rename.sv
module decode_rename
import cpu_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             valid_i,
    input  fetch_pkt_t       pkt_i,
    input  logic             rob_full_i,
    input  logic [tag_w-1:0] rob_tag_i,
    input  rob_read_t        src1_i,
    input  rob_read_t        src2_i,
    input  logic             rs_full_i,
    input  commit_t          commit_i,
    output logic             pop_o,
    output logic             alloc_o,
    output logic [4:0]       alloc_rd_o,
    output logic             alloc_writes_o,
    output logic [xlen-1:0]  alloc_pc_o,
    output logic [tag_w-1:0] src1_tag_o,
    output logic [tag_w-1:0] src2_tag_o,
    output dispatch_t        disp_o
);

    inst_u            ins;
    alu_op_e          op;
    logic [xlen-1:0]  imm;
    logic             use_imm;
    logic             writes;
    logic [31:0]      rat_valid;
    logic [tag_w-1:0] rat_tag [32];
    logic [xlen-1:0]  regfile [32];
    // mirrors the rob head, the tag of the next commit
    logic [tag_w-1:0] commit_tag;

    assign ins = pkt_i.inst;

    always_comb begin
        op      = alu_pass;
        use_imm = 1'b1;
        writes  = 1'b0;
        imm     = '0;
        case (ins.r.opcode)
            op_reg, op_imm: begin
                writes  = 1'b1;
                use_imm = ins.r.opcode == op_imm;
                imm     = {{20{ins.i.imm[11]}}, ins.i.imm};
                case (ins.r.funct3)
                    3'b000:  op = (!use_imm && ins.r.funct7[5]) ? alu_sub : alu_add;
                    3'b001:  op = alu_sll;
                    3'b010:  op = alu_slt;
                    3'b011:  op = alu_sltu;
                    3'b100:  op = alu_xor;
                    3'b101:  op = ins.r.funct7[5] ? alu_sra : alu_srl;
                    3'b110:  op = alu_or;
                    default: op = alu_and;
                endcase
            end
            op_lui: begin
                writes = 1'b1;
                imm    = {ins.r.funct7, ins.r.rs2, ins.r.rs1, ins.r.funct3, 12'h000};
            end
            default: ;
        endcase
    end

    assign pop_o          = valid_i && !rob_full_i && !rs_full_i;
    assign alloc_o        = pop_o;
    assign alloc_rd_o     = ins.r.rd;
    assign alloc_writes_o = writes && ins.r.rd != 5'd0;
    assign alloc_pc_o     = pkt_i.pc;
    assign src1_tag_o     = rat_tag[ins.r.rs1];
    assign src2_tag_o     = rat_tag[ins.r.rs2];

    always_comb begin
        disp_o          = '0;
        disp_o.valid    = pop_o;
        disp_o.tag      = rob_tag_i;
        disp_o.rd       = ins.r.rd;
        disp_o.writes   = alloc_writes_o;
        disp_o.op       = op;
        disp_o.pc       = pkt_i.pc;
        // unmapped reads the register file, mapped waits on the rob
        disp_o.src1_tag = src1_tag_o;
        disp_o.src1_rdy = !rat_valid[ins.r.rs1] || src1_i.done || op == alu_pass;
        disp_o.src1_val = rat_valid[ins.r.rs1] ? src1_i.value : regfile[ins.r.rs1];
        disp_o.src2_tag = src2_tag_o;
        disp_o.src2_rdy = !rat_valid[ins.r.rs2] || src2_i.done || use_imm;
        disp_o.src2_val = rat_valid[ins.r.rs2] ? src2_i.value : regfile[ins.r.rs2];
        if (use_imm) disp_o.src2_val = imm;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rat_valid  <= '0;
            commit_tag <= '0;
            for (int i = 0; i < 32; i++) regfile[i] <= '0;
        end else begin
            if (commit_i.valid) begin
                commit_tag <= commit_tag + 1'b1;
                if (commit_i.writes) begin
                    regfile[commit_i.rd] <= commit_i.data;
                    if (rat_tag[commit_i.rd] == commit_tag) rat_valid[commit_i.rd] <= 1'b0;
                end
            end
            // a new mapping wins over a clear in the same cycle
            if (alloc_o && alloc_writes_o) rat_valid[ins.r.rd] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_o && alloc_writes_o) rat_tag[ins.r.rd] <= rob_tag_i;
    end

endmodule

// File: reservation_station.sv
module reservation_station
import cpu_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  dispatch_t disp_i,
    input  cdb_t      cdb_i,
    output logic      full_o,
    output issue_t    issue_o
);

    dispatch_t             ent [rs_depth];
    logic [rs_depth-1:0]   ent_valid;
    // older[j][i] set when entry j was written before entry i
    logic [rs_depth-1:0]   older [rs_depth];
    logic [rs_depth-1:0]   ready;
    logic [rs_depth-1:0]   free_oh;
    logic [rs_depth-1:0]   pick_oh;

    assign full_o = &ent_valid;

    always_comb begin
        free_oh = '0;
        pick_oh = '0;
        issue_o = '0;
        for (int i = 0; i < rs_depth; i++) begin
            ready[i] = ent_valid[i] && ent[i].src1_rdy && ent[i].src2_rdy;
        end
        for (int i = 0; i < rs_depth; i++) begin
            if (!ent_valid[i] && free_oh == '0) free_oh[i] = 1'b1;
            pick_oh[i] = ready[i];
            for (int j = 0; j < rs_depth; j++) begin
                if (ready[j] && older[j][i]) pick_oh[i] = 1'b0;
            end
            if (pick_oh[i]) begin
                issue_o.valid = 1'b1;
                issue_o.tag   = ent[i].tag;
                issue_o.op    = ent[i].op;
                issue_o.src_a = ent[i].src1_val;
                issue_o.src_b = ent[i].src2_val;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ent_valid <= '0;
        end else begin
            for (int i = 0; i < rs_depth; i++) begin
                if (pick_oh[i]) ent_valid[i] <= 1'b0;
                if (disp_i.valid && free_oh[i]) ent_valid[i] <= 1'b1;
            end
        end
    end

    // operand capture from the cdb and age tracking
    always_ff @(posedge clk) begin
        for (int i = 0; i < rs_depth; i++) begin
            if (cdb_i.valid && !ent[i].src1_rdy && ent[i].src1_tag == cdb_i.tag) begin
                ent[i].src1_val <= cdb_i.data;
                ent[i].src1_rdy <= 1'b1;
            end
            if (cdb_i.valid && !ent[i].src2_rdy && ent[i].src2_tag == cdb_i.tag) begin
                ent[i].src2_val <= cdb_i.data;
                ent[i].src2_rdy <= 1'b1;
            end
            if (disp_i.valid && free_oh[i]) begin
                ent[i]   <= disp_i;
                older[i] <= '0;
                for (int j = 0; j < rs_depth; j++) older[j][i] <= j != i;
            end
        end
    end

endmodule

// File: alu_unit.sv
module alu_unit
import cpu_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  issue_t issue_i,
    output cdb_t   cdb_o
);

    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    logic [xlen-1:0] result;

    assign a = issue_i.src_a;
    assign b = issue_i.src_b;

    // shifts take the low five bits of b
    always_comb begin
        case (issue_i.op)
            alu_add:  result = a + b;
            alu_sub:  result = a - b;
            alu_and:  result = a & b;
            alu_or:   result = a | b;
            alu_xor:  result = a ^ b;
            alu_slt:  result = {{(xlen - 1){1'b0}}, $signed(a) < $signed(b)};
            alu_sltu: result = {{(xlen - 1){1'b0}}, a < b};
            alu_sll:  result = a << b[4:0];
            alu_srl:  result = a >> b[4:0];
            alu_sra:  result = $unsigned($signed(a) >>> b[4:0]);
            default:  result = b;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) cdb_o.valid <= 1'b0;
        else cdb_o.valid <= issue_i.valid;
    end

    always_ff @(posedge clk) begin
        cdb_o.tag  <= issue_i.tag;
        cdb_o.data <= result;
    end

endmodule

// File: rob.sv
module rob
import cpu_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             alloc_i,
    input  logic [4:0]       alloc_rd_i,
    input  logic             alloc_writes_i,
    input  logic [xlen-1:0]  alloc_pc_i,
    input  logic [tag_w-1:0] src1_tag_i,
    input  logic [tag_w-1:0] src2_tag_i,
    input  cdb_t             cdb_i,
    output logic             full_o,
    output logic [tag_w-1:0] tag_o,
    output rob_read_t        src1_o,
    output rob_read_t        src2_o,
    output commit_t          commit_o
);

    logic [rob_depth-1:0] done_q;
    logic [rob_depth-1:0] writes_q;
    logic [xlen-1:0]      value_q [rob_depth];
    logic [xlen-1:0]      pc_q    [rob_depth];
    logic [4:0]           rd_q    [rob_depth];
    logic [tag_w-1:0]     head;
    logic [tag_w-1:0]     tail;
    logic [tag_w:0]       count;
    logic                 retire;

    // operand lookup with same-cycle cdb bypass
    function automatic rob_read_t read_entry(input logic [tag_w-1:0] tag);
        rob_read_t r;
        r.done  = done_q[tag];
        r.value = value_q[tag];
        if (cdb_i.valid && cdb_i.tag == tag) begin
            r.done  = 1'b1;
            r.value = cdb_i.data;
        end
        return r;
    endfunction

    assign full_o = count == (tag_w + 1)'(rob_depth);
    assign tag_o  = tail;
    assign src1_o = read_entry(src1_tag_i);
    assign src2_o = read_entry(src2_tag_i);
    assign retire = count != '0 && done_q[head];

    assign commit_o.valid  = retire;
    assign commit_o.pc     = pc_q[head];
    assign commit_o.rd     = rd_q[head];
    assign commit_o.writes = writes_q[head];
    assign commit_o.data   = value_q[head];

    always_ff @(posedge clk) begin
        if (rst) begin
            head   <= '0;
            tail   <= '0;
            count  <= '0;
            done_q <= '0;
        end else begin
            if (cdb_i.valid) done_q[cdb_i.tag] <= 1'b1;
            if (alloc_i) begin
                done_q[tail] <= 1'b0;
                tail         <= tail + 1'b1;
            end
            if (retire) head <= head + 1'b1;
            case ({alloc_i, retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cdb_i.valid) value_q[cdb_i.tag] <= cdb_i.data;
        if (alloc_i) begin
            pc_q[tail]     <= alloc_pc_i;
            rd_q[tail]     <= alloc_rd_i;
            writes_q[tail] <= alloc_writes_i;
        end
    end

endmodule

// File: cpu.sv
module cpu
import cpu_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            wb_ack_i,
    input  logic [xlen-1:0] wb_dat_i,
    output wb_req_t         wb_o,
    output commit_t         commit_o
);

    logic             iq_full;
    logic             iq_push;
    fetch_pkt_t       fetch_pkt;
    logic             iq_valid;
    fetch_pkt_t       iq_pkt;
    logic             iq_pop;
    logic             rob_full;
    logic [tag_w-1:0] rob_tag;
    logic [tag_w-1:0] src1_tag;
    logic [tag_w-1:0] src2_tag;
    rob_read_t        src1_rd;
    rob_read_t        src2_rd;
    logic             alloc;
    logic [4:0]       alloc_rd;
    logic             alloc_writes;
    logic [xlen-1:0]  alloc_pc;
    dispatch_t        disp;
    logic             rs_full;
    issue_t           issue;
    cdb_t             cdb;

    fetch_unit i_fetch (
        .clk       (clk),
        .rst       (rst),
        .wb_ack_i  (wb_ack_i),
        .wb_dat_i  (wb_dat_i),
        .iq_full_i (iq_full),
        .wb_o      (wb_o),
        .push_o    (iq_push),
        .pkt_o     (fetch_pkt)
    );

    inst_queue i_queue (
        .clk     (clk),
        .rst     (rst),
        .push_i  (iq_push),
        .pkt_i   (fetch_pkt),
        .pop_i   (iq_pop),
        .full_o  (iq_full),
        .valid_o (iq_valid),
        .pkt_o   (iq_pkt)
    );

    decode_rename i_decode (
        .clk            (clk),
        .rst            (rst),
        .valid_i        (iq_valid),
        .pkt_i          (iq_pkt),
        .rob_full_i     (rob_full),
        .rob_tag_i      (rob_tag),
        .src1_i         (src1_rd),
        .src2_i         (src2_rd),
        .rs_full_i      (rs_full),
        .commit_i       (commit_o),
        .pop_o          (iq_pop),
        .alloc_o        (alloc),
        .alloc_rd_o     (alloc_rd),
        .alloc_writes_o (alloc_writes),
        .alloc_pc_o     (alloc_pc),
        .src1_tag_o     (src1_tag),
        .src2_tag_o     (src2_tag),
        .disp_o         (disp)
    );

    reservation_station i_station (
        .clk     (clk),
        .rst     (rst),
        .disp_i  (disp),
        .cdb_i   (cdb),
        .full_o  (rs_full),
        .issue_o (issue)
    );

    alu_unit i_alu (
        .clk     (clk),
        .rst     (rst),
        .issue_i (issue),
        .cdb_o   (cdb)
    );

    rob i_rob (
        .clk            (clk),
        .rst            (rst),
        .alloc_i        (alloc),
        .alloc_rd_i     (alloc_rd),
        .alloc_writes_i (alloc_writes),
        .alloc_pc_i     (alloc_pc),
        .src1_tag_i     (src1_tag),
        .src2_tag_i     (src2_tag),
        .cdb_i          (cdb),
        .full_o         (rob_full),
        .tag_o          (rob_tag),
        .src1_o         (src1_rd),
        .src2_o         (src2_rd),
        .commit_o       (commit_o)
    );

endmodule

// File: cpu_props.sv
module cpu_props
import cpu_pkg::*;
(
    input logic    clk,
    input logic    rst,
    input logic    wb_ack_i,
    input wb_req_t wb_i,
    input commit_t commit_i
);

    logic [31:0] last_pc;
    logic        have_last;

    always_ff @(posedge clk) begin
        if (rst) begin
            have_last <= 1'b0;
            last_pc   <= '0;
        end else if (commit_i.valid) begin
            have_last <= 1'b1;
            last_pc   <= commit_i.pc;
        end
    end

    a_stb_cyc: assert property (@(posedge clk) disable iff (rst)
        wb_i.stb |-> wb_i.cyc)
        else $error("wishbone stb high without cyc");

    // classic cycle holds the request until ack
    a_adr_hold: assert property (@(posedge clk) disable iff (rst)
        (wb_i.stb && !wb_ack_i) |=> (wb_i.stb && $stable(wb_i.adr)))
        else $error("wishbone request dropped or address changed before ack");

    a_adr_align: assert property (@(posedge clk) disable iff (rst)
        wb_i.stb |-> wb_i.adr[1:0] == 2'b00)
        else $error("wishbone address not word aligned");

    a_first_pc: assert property (@(posedge clk) disable iff (rst)
        (commit_i.valid && !have_last) |-> commit_i.pc == reset_pc)
        else $error("first commit is not at the reset pc");

    a_pc_step: assert property (@(posedge clk) disable iff (rst)
        (commit_i.valid && have_last) |-> commit_i.pc == last_pc + 32'd4)
        else $error("commit pc does not follow the previous one by four");

endmodule

bind cpu cpu_props i_props (
    .clk      (clk),
    .rst      (rst),
    .wb_ack_i (wb_ack_i),
    .wb_i     (wb_o),
    .commit_i (commit_o)
);

// File: tb_cpu.sv
module tb_cpu
import cpu_pkg::*;
();

    logic        clk;
    logic        rst;
    logic        wb_ack;
    logic [31:0] wb_dat;
    wb_req_t     wb_o;
    commit_t     commit_o;

    // program and expected commits, layout given in cpu_input.txt
    logic [31:0] data_mem [256];
    int          prog_count;
    int          exp_count;
    logic        loaded;

    logic        req_seen;
    int unsigned wait_cnt;

    int          init_errors;
    int          commit_errors;
    int          timeouts;
    int          checked;

    cpu i_dut (
        .clk      (clk),
        .rst      (rst),
        .wb_ack_i (wb_ack),
        .wb_dat_i (wb_dat),
        .wb_o     (wb_o),
        .commit_o (commit_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic int report_mismatch(input string name, input logic [31:0] got,
                                           input logic [31:0] exp);
        $display("Fail %s at commit %0d: got %h expected %h", name, checked, got, exp);
        return 1;
    endfunction

    // word addressed program, addi x0, x0, 0 beyond its end
    function automatic logic [31:0] fetch_word(input logic [31:0] adr);
        int idx;
        idx = int'(adr >> 2);
        if (idx < prog_count) return data_mem[idx + 1];
        return 32'h0000_0013;
    endfunction

    task automatic hold_reset();
        for (int i = 0; i < 8; i++) begin
            @(posedge clk);
            if (i == 7) rst <= 1'b0;
            @(negedge clk);
            if (wb_o.cyc !== 1'b0) init_errors += report_mismatch("wb_o.cyc", 32'(wb_o.cyc), 0);
            if (wb_o.stb !== 1'b0) init_errors += report_mismatch("wb_o.stb", 32'(wb_o.stb), 0);
            if (commit_o.valid !== 1'b0) begin
                init_errors += report_mismatch("commit_o.valid", 32'(commit_o.valid), 0);
            end
        end
    endtask

    task automatic finish_run();
        int total;
        total = init_errors + commit_errors + timeouts;
        $display("errors: %0d total, %0d init, %0d commit, %0d timeout, %0d of %0d commits checked",
                 total, init_errors, commit_errors, timeouts, checked, exp_count);
        if (total == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    endtask

    initial begin
        rst         = 1'b1;
        loaded      = 1'b0;
        init_errors = 0;
        void'($urandom(32'hadfa_e4a4));
        $readmemh("cpu_input.txt", data_mem);
        prog_count = data_mem[0];
        exp_count  = data_mem[prog_count + 1];
        loaded     = 1'b1;
        if (prog_count <= 0 || exp_count <= 0) begin
            $display("data file cpu_input.txt holds no program or no expected commits");
            init_errors++;
        end
        hold_reset();
        wait (checked >= exp_count);
        repeat (2) @(posedge clk);
        finish_run();
    end

    // wishbone slave with 0 to 3 random wait cycles
    initial begin
        int unsigned delay;
        wb_ack   = 1'b0;
        wb_dat   = '0;
        req_seen = 1'b0;
        wait_cnt = 0;
        forever begin
            @(posedge clk);
            if (rst) begin
                wb_ack   <= 1'b0;
                req_seen <= 1'b0;
            end else if (wb_ack) begin
                wb_ack <= 1'b0;
            end else if (wb_o.cyc && wb_o.stb) begin
                if (!req_seen) begin
                    delay = $urandom_range(3, 0);
                end else begin
                    delay = wait_cnt;
                end
                if (delay == 0) begin
                    wb_ack   <= 1'b1;
                    wb_dat   <= fetch_word(wb_o.adr);
                    req_seen <= 1'b0;
                end else begin
                    req_seen <= 1'b1;
                    wait_cnt <= delay - 1;
                end
            end
        end
    end

    // commit port is stable at the falling edge
    initial begin
        int base;
        checked       = 0;
        commit_errors = 0;
        forever begin
            @(negedge clk);
            if (!rst && commit_o.valid && checked < exp_count) begin
                base = prog_count + 2 + 4 * checked;
                if (commit_o.pc !== data_mem[base]) begin
                    commit_errors += report_mismatch("commit_o.pc", commit_o.pc, data_mem[base]);
                end
                if (commit_o.rd !== data_mem[base + 1][4:0]) begin
                    commit_errors += report_mismatch("commit_o.rd", 32'(commit_o.rd),
                                                     32'(data_mem[base + 1][4:0]));
                end
                if (commit_o.writes !== data_mem[base + 2][0]) begin
                    commit_errors += report_mismatch("commit_o.writes", 32'(commit_o.writes),
                                                     32'(data_mem[base + 2][0]));
                end
                // data is architectural only for a register write
                if (data_mem[base + 2][0] && commit_o.data !== data_mem[base + 3]) begin
                    commit_errors += report_mismatch("commit_o.data", commit_o.data,
                                                     data_mem[base + 3]);
                end
                checked++;
            end
        end
    end

    initial begin
        timeouts = 0;
        wait (loaded);
        repeat (exp_count * 20 + 500) @(posedge clk);
        $display("timeout: only %0d of %0d expected commits seen", checked, exp_count);
        timeouts = 1;
        finish_run();
    end

endmodule

// File: cpu_input.txt
// program word count, program words, expected commit count,
// then commit records of pc, rd, write flag, data (two records per line)
1F
123450B7 67808093 FFF00113 002081B3 40118233 0020F2B3 0040E333 0FF0C393
00112433 001134B3 00409513 01C15593 401006B3 4086D613 00B11733 00B6D7B3
40B6D833 00508013 001008B3 FFB6A913 FFF0B993 00F6EA13 7F06FA93 00DA4B33
001080B3 001080B3 41108BB3 00002283 00028C33 FFFFFCB7 800C8C93
23
00000000 01 1 12345000   00000004 01 1 12345678
00000008 02 1 FFFFFFFF   0000000C 03 1 12345677
00000010 04 1 FFFFFFFF   00000014 05 1 12345678
00000018 06 1 FFFFFFFF   0000001C 07 1 12345687
00000020 08 1 00000001   00000024 09 1 00000000
00000028 0A 1 23456780   0000002C 0B 1 0000000F
00000030 0D 1 EDCBA988   00000034 0C 1 FFEDCBA9
00000038 0E 1 FFFF8000   0000003C 0F 1 0001DB97
00000040 10 1 FFFFDB97   00000044 00 0 00000000
00000048 11 1 12345678   0000004C 12 1 00000001
00000050 13 1 00000001   00000054 14 1 EDCBA98F
00000058 15 1 00000180   0000005C 16 1 00000007
00000060 01 1 2468ACF0   00000064 01 1 48D159E0
00000068 17 1 369D0368   0000006C 05 0 00000000
00000070 18 1 12345678   00000074 19 1 FFFFF000
00000078 19 1 FFFFE800   0000007C 00 0 00000000
00000080 00 0 00000000   00000084 00 0 00000000
00000088 00 0 00000000

// File: tb.f
cpu_pkg.sv
fetch_unit.sv
inst_queue.sv
decode_rename.sv
reservation_station.sv
alu_unit.sv
rob.sv
cpu.sv
cpu_props.sv
tb_cpu.sv

// File: run.sh
#!/usr/bin/env bash
# compile and run the cpu testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_cpu -f tb.f -o sim_cpu \
    && ./obj_dir/sim_cpu | tee sim.log \
    && grep -q "^TESTBENCH PASSED$" sim.log \
    && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }
